// File: rob.f
rob_pkg.sv
rob_entry_array.sv
rob_pointers.sv
rob_commit_select.sv
rob_top.sv
rob_chk.sv
rob_tb_clock.sv
rob_tb_checker.sv
rob_tb.sv

// File: rob_chk.sv
//----------------------------------------------------------------------
// concurrent assertions on occupancy and commit rules
// bound into every rob_pointers instance
//----------------------------------------------------------------------
`timescale 1ns/1ns

module rob_chk #(
	parameter int rob_depth = rob_pkg::DEFAULT_ROB_DEPTH
) (
	input logic clock,
	input logic reset,
	input logic [$clog2(rob_depth+1)-1:0] count,
	input logic [1:0] commit_count,
	input logic flush
);

	int failures = 0;	// read by the testbench at the end of the run

	// occupancy never passes the buffer size
	count_bound: assert property (@(posedge clock) disable iff (reset)
		count <= ($clog2(rob_depth+1))'(rob_depth))
	else
	begin
		$error("occupancy %0d above depth %0d", count, rob_depth);
		failures++;
	end

	// a second commit slot needs a first one, so two live entries
	commit_pair: assert property (@(posedge clock) disable iff (reset)
		(commit_count == 2'd2) |-> (count >= ($clog2(rob_depth+1))'(2)))
	else
	begin
		$error("second commit slot with only %0d entries", count);
		failures++;
	end

	flush_in_reset: assert property (@(posedge clock) reset |-> !flush)
	else
	begin
		$error("flush raised during reset");
		failures++;
	end

endmodule

bind rob_pointers rob_chk #(.rob_depth(rob_depth)) chk (
	.clock(clock),
	.reset(reset),
	.count(count),
	.commit_count(commit_count),
	.flush(flush)
);

// File: rob_commit_select.sv
//----------------------------------------------------------------------
// in-order commit choice over the two oldest entries
// purely combinational, feeds the pointers and the entry array
//----------------------------------------------------------------------
`timescale 1ns/1ns

module rob_commit_select #(
	parameter int rob_depth = rob_pkg::DEFAULT_ROB_DEPTH
) (
	input logic [$clog2(rob_depth+1)-1:0] count,
	// oldest entry
	input logic head_done,
	input logic head_is_branch,
	input logic head_mispredict,
	// second oldest entry
	input logic next_done,
	input logic next_is_branch,
	input logic next_mispredict,
	output logic [1:0] commit_count,
	output logic flush
);

	localparam int cnt_w = $clog2(rob_depth+1);

	logic head_commit;
	logic next_commit;
	logic head_bad_branch;	// head resolved as a wrong-path branch
	logic next_bad_branch;

	assign head_bad_branch = head_is_branch && head_mispredict;
	assign next_bad_branch = next_is_branch && next_mispredict;

	// the head leaves once it is occupied and executed
	assign head_commit = (count != '0) && head_done;

	// head+1 only behind a committing head, and never behind a bad branch
	// since everything after that branch is on the wrong path
	assign next_commit = head_commit
		&& (count >= cnt_w'(2))
		&& next_done
		&& !head_bad_branch;

	always_comb
	begin
		commit_count = 2'd0;
		if (next_commit)
		begin
			commit_count = 2'd2;
		end
		else if (head_commit)
		begin
			commit_count = 2'd1;
		end
	end

	// a bad branch going out drops every younger entry
	// at most one of the two can raise it, the head blocks the second slot
	assign flush = (head_commit && head_bad_branch)
		|| (next_commit && next_bad_branch);

endmodule

// File: rob_entry_array.sv
//----------------------------------------------------------------------
// per-entry storage of the reorder buffer
// dispatch and completion write at the edge, head and head+1 read out
//----------------------------------------------------------------------
`timescale 1ns/1ns

module rob_entry_array #(
	parameter int rob_depth = rob_pkg::DEFAULT_ROB_DEPTH
) (
	input logic clock,
	input logic reset,
	// dispatch writes
	input logic wr1_en,
	input logic wr2_en,
	input logic [$clog2(rob_depth)-1:0] wr1_idx,
	input logic [$clog2(rob_depth)-1:0] wr2_idx,
	input rob_pkg::pc_t wr1_pc,
	input rob_pkg::pc_t wr2_pc,
	input rob_pkg::arn_t wr1_arn,
	input rob_pkg::arn_t wr2_arn,
	input rob_pkg::prn_t wr1_prn,
	input rob_pkg::prn_t wr2_prn,
	input logic wr1_is_branch,
	input logic wr2_is_branch,
	// completion from the two functional units
	input logic fu1_done,
	input logic fu2_done,
	input logic [$clog2(rob_depth)-1:0] fu1_idx,
	input logic [$clog2(rob_depth)-1:0] fu2_idx,
	input logic fu1_mispredict,
	input logic fu2_mispredict,
	input rob_pkg::pc_t fu1_target_pc,
	input rob_pkg::pc_t fu2_target_pc,
	// commit and flush
	input logic [1:0] commit_count,
	input logic flush,
	input logic [$clog2(rob_depth)-1:0] head_idx,
	// oldest entry
	output logic head_valid,
	output logic head_done,
	output rob_pkg::pc_t head_pc,
	output rob_pkg::arn_t head_arn,
	output rob_pkg::prn_t head_prn,
	output logic head_is_branch,
	output logic head_mispredict,
	output rob_pkg::pc_t head_target_pc,
	// second oldest entry
	output logic next_valid,
	output logic next_done,
	output rob_pkg::pc_t next_pc,
	output rob_pkg::arn_t next_arn,
	output rob_pkg::prn_t next_prn,
	output logic next_is_branch,
	output logic next_mispredict,
	output rob_pkg::pc_t next_target_pc
);
	import rob_pkg::*;

	localparam int idx_w = $clog2(rob_depth);

	logic [rob_depth-1:0] valid;		// entry holds a live instruction
	logic [rob_depth-1:0] done;			// executed, ready to retire
	logic [rob_depth-1:0] is_branch;
	logic [rob_depth-1:0] mispredict;
	pc_t pc [rob_depth];
	pc_t target_pc [rob_depth];
	arn_t arn [rob_depth];
	prn_t prn [rob_depth];
	logic [idx_w-1:0] next_idx;			// head+1, wraps by overflow

	assign next_idx = head_idx + idx_w'(1);

	// valid and done flags
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			valid <= '0;
			done <= '0;
		end
		else if (flush)
		begin
			valid <= '0;	// committing entries and all younger ones go together
		end
		else
		begin
			if (commit_count != 2'd0)
			begin
				valid[head_idx] <= 1'b0;
			end
			if (commit_count == 2'd2)
			begin
				valid[next_idx] <= 1'b0;
			end
			// unit 2 first so unit 1 wins on the same index
			if (fu2_done && valid[fu2_idx])
			begin
				done[fu2_idx] <= 1'b1;
			end
			if (fu1_done && valid[fu1_idx])
			begin
				done[fu1_idx] <= 1'b1;
			end
			if (wr1_en)
			begin
				valid[wr1_idx] <= 1'b1;
				done[wr1_idx] <= 1'b0;	// fresh slot, not yet executed
			end
			if (wr2_en)
			begin
				valid[wr2_idx] <= 1'b1;
				done[wr2_idx] <= 1'b0;
			end
		end
	end

	// payload fields
	always_ff @(posedge clock)
	begin
		if (fu2_done && valid[fu2_idx])
		begin
			mispredict[fu2_idx] <= fu2_mispredict;
			target_pc[fu2_idx] <= fu2_target_pc;
		end
		if (fu1_done && valid[fu1_idx])
		begin
			mispredict[fu1_idx] <= fu1_mispredict;
			target_pc[fu1_idx] <= fu1_target_pc;
		end
		if (wr1_en)
		begin
			pc[wr1_idx] <= wr1_pc;
			arn[wr1_idx] <= wr1_arn;
			prn[wr1_idx] <= wr1_prn;
			is_branch[wr1_idx] <= wr1_is_branch;
			mispredict[wr1_idx] <= 1'b0;
		end
		if (wr2_en)
		begin
			pc[wr2_idx] <= wr2_pc;
			arn[wr2_idx] <= wr2_arn;
			prn[wr2_idx] <= wr2_prn;
			is_branch[wr2_idx] <= wr2_is_branch;
			mispredict[wr2_idx] <= 1'b0;
		end
	end

	// read ports for the commit side
	assign head_valid = valid[head_idx];
	assign head_done = done[head_idx];
	assign head_pc = pc[head_idx];
	assign head_arn = arn[head_idx];
	assign head_prn = prn[head_idx];
	assign head_is_branch = is_branch[head_idx];
	assign head_mispredict = mispredict[head_idx];
	assign head_target_pc = target_pc[head_idx];

	assign next_valid = valid[next_idx];
	assign next_done = done[next_idx];
	assign next_pc = pc[next_idx];
	assign next_arn = arn[next_idx];
	assign next_prn = prn[next_idx];
	assign next_is_branch = is_branch[next_idx];
	assign next_mispredict = mispredict[next_idx];
	assign next_target_pc = target_pc[next_idx];

endmodule

// File: rob_pkg.sv
//----------------------------------------------------------------------
// shared widths and constants for the reorder buffer
// every block imports this package, the top level sets the depth
//----------------------------------------------------------------------

package rob_pkg;

	// program counter, full 64-bit address
	typedef logic [63:0] pc_t;

	// architectural register number, 32 registers
	typedef logic [4:0] arn_t;

	// physical register number into a 64-entry register file
	typedef logic [5:0] prn_t;

	// register shown on an idle commit slot
	// the rename stage treats it as the hard zero register
	localparam arn_t ZERO_REG = 5'd31;

	// default buffer size, must stay a power of two
	// so that head and tail wrap by plain overflow
	localparam int DEFAULT_ROB_DEPTH = 16;

endpackage

// File: rob_pointers.sv
//----------------------------------------------------------------------
// head, tail and occupancy of the reorder buffer
// decides which dispatched instructions fit, the only room check
//----------------------------------------------------------------------
`timescale 1ns/1ns

module rob_pointers #(
	parameter int rob_depth = rob_pkg::DEFAULT_ROB_DEPTH
) (
	input logic clock,
	input logic reset,
	input logic inst1_load,
	input logic inst2_load,
	input logic [1:0] commit_count,
	input logic flush,
	output logic [$clog2(rob_depth)-1:0] head,
	output logic [$clog2(rob_depth)-1:0] tail,
	output logic [$clog2(rob_depth+1)-1:0] count,
	output logic accept1,
	output logic accept2,
	output logic full
);

	localparam int idx_w = $clog2(rob_depth);
	localparam int cnt_w = $clog2(rob_depth+1);	// holds 0..rob_depth

	logic [cnt_w-1:0] free_slots;
	logic [idx_w-1:0] next_head;
	logic [1:0] accept_count;	// 0, 1 or 2 new entries

	assign free_slots = cnt_w'(rob_depth) - count;

	// no dispatch lands in a flush cycle, the tail is being pulled back
	assign accept1 = inst1_load && (free_slots != '0) && !flush;
	// second slot rides only with the first
	assign accept2 = inst1_load && inst2_load && (free_slots >= cnt_w'(2)) && !flush;

	// fewer than a full pair of slots left
	assign full = free_slots < cnt_w'(2);

	assign accept_count = {1'b0, accept1} + {1'b0, accept2};
	assign next_head = head + idx_w'(commit_count);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end
		else
		begin
			head <= next_head;	// commit is always taken
			if (flush)
			begin
				// younger entries are gone, buffer restarts right after the branch
				tail <= next_head;
				count <= '0;
			end
			else
			begin
				tail <= tail + idx_w'(accept_count);
				count <= count + cnt_w'(accept_count) - cnt_w'(commit_count);
			end
		end
	end

endmodule

// File: rob_tb.sv
//----------------------------------------------------------------------
// reorder buffer testbench top, replays rob_trace.txt into the DUT
// drives on falling edges, checker and assertions do the comparing
//----------------------------------------------------------------------
`timescale 1ns/1ns

module rob_tb;
	import rob_pkg::*;

	localparam int rob_depth = DEFAULT_ROB_DEPTH;
	localparam int idx_w = $clog2(rob_depth);

	logic clock, reset;
	logic inst1_load, inst2_load, inst1_is_branch, inst2_is_branch;
	pc_t inst1_pc, inst2_pc;
	arn_t inst1_arn_dest, inst2_arn_dest;
	prn_t inst1_prn_dest, inst2_prn_dest;
	logic fu1_done, fu2_done, fu1_mispredict, fu2_mispredict;
	logic [idx_w-1:0] fu1_idx, fu2_idx, inst1_rob_idx, inst2_rob_idx, exp_idx;
	pc_t fu1_target_pc, fu2_target_pc;
	logic full, idx_check;
	logic commit1_valid, commit1_is_branch, commit1_mispredict;
	logic commit2_valid, commit2_is_branch, commit2_mispredict;
	pc_t commit1_pc, commit1_target_pc, commit2_pc, commit2_target_pc;
	arn_t commit1_arn_dest, commit2_arn_dest;
	prn_t commit1_prn_dest, commit2_prn_dest;
	int pending, check_errors, trace_errors, rows, limit_cycles, fd, total;

	rob_tb_clock u_clock (.clock(clock), .reset(reset));

	rob_top #(.rob_depth(rob_depth)) DUT (.*);

	rob_tb_checker #(.rob_depth(rob_depth)) u_checker (
		.clock(clock), .reset(reset),
		.inst1_load(inst1_load), .inst2_load(inst2_load), .full(full),
		.commit1_valid(commit1_valid), .commit1_pc(commit1_pc),
		.commit1_arn_dest(commit1_arn_dest), .commit1_prn_dest(commit1_prn_dest),
		.commit1_is_branch(commit1_is_branch), .commit1_mispredict(commit1_mispredict),
		.commit1_target_pc(commit1_target_pc),
		.commit2_valid(commit2_valid), .commit2_pc(commit2_pc),
		.commit2_arn_dest(commit2_arn_dest), .commit2_prn_dest(commit2_prn_dest),
		.commit2_is_branch(commit2_is_branch), .commit2_mispredict(commit2_mispredict),
		.commit2_target_pc(commit2_target_pc),
		.inst1_rob_idx(inst1_rob_idx), .inst2_rob_idx(inst2_rob_idx),
		.idx_check(idx_check), .exp_idx(exp_idx),
		.pending(pending), .error_total(check_errors)
	);

	task automatic idle_inputs();
		inst1_load = 1'b0;
		inst2_load = 1'b0;
		inst1_pc = '0;
		inst2_pc = '0;
		inst1_arn_dest = '0;
		inst2_arn_dest = '0;
		inst1_prn_dest = '0;
		inst2_prn_dest = '0;
		inst1_is_branch = 1'b0;
		inst2_is_branch = 1'b0;
		fu1_done = 1'b0;
		fu2_done = 1'b0;
		fu1_idx = '0;
		fu2_idx = '0;
		fu1_mispredict = 1'b0;
		fu2_mispredict = 1'b0;
		fu1_target_pc = '0;
		fu2_target_pc = '0;
		idx_check = 1'b0;
		exp_idx = '0;
	endtask

	// one strobe cycle, then a short random gap
	task automatic pulse_and_gap();
		int gap;
		gap = int'($urandom % 3);
		@(negedge clock);
		idle_inputs();
		repeat (gap) @(negedge clock);
	endtask

	// let the open test drain, then a few cycles to catch stray commits
	task automatic drain_test();
		while (pending != 0) @(negedge clock);
		repeat (4) @(negedge clock);
	endtask

	task automatic count_rows();
		int tfd;
		logic [8*160-1:0] line;
		rows = 0;
		tfd = $fopen("rob_trace.txt", "r");
		if (tfd != 0)
		begin
			while ($fgets(line, tfd) > 0) rows++;
			$fclose(tfd);
		end
	endtask

	task automatic check_fields(input byte kind, input int got, input int want);
		if (got != want)
		begin
			$display("trace row of kind '%c' has %0d fields, expected %0d", kind, got, want);
			trace_errors++;
		end
	endtask

	task automatic run_trace();
		byte kind;
		logic [8*160-1:0] rest;
		logic [8*24-1:0] name;
		int l1, l2, b1, b2, d1, d2, m1, m2, n, dual, code;
		logic [63:0] idx, i1, i2, mis;
		pc_t p1, p2, t1, t2;
		while ($fscanf(fd, " %c", kind) == 1)
		begin
			case (kind)
				"#": code = $fgets(rest, fd);	// comment up to end of line
				"T":
				begin
					code = $fscanf(fd, "%s", name);
					check_fields(kind, code, 1);
					drain_test();
					u_checker.start_test(name);
				end
				"E":
				begin
					code = $fscanf(fd, "%h %h %d %d", p1, mis, n, dual);
					check_fields(kind, code, 4);
					for (int k = 0; k < n; k++)
						u_checker.expect_commit(p1 + pc_t'(4 * k), mis[0], dual[0] != 1'b0);
				end
				"D":
				begin
					code = $fscanf(fd, "%d %d %h %h %d %d %h", l1, l2, p1, p2, b1, b2, idx);
					check_fields(kind, code, 7);
					if (l1[0])
						u_checker.note_dispatch(p1, b1[0]);
					if (l2[0])
						u_checker.note_dispatch(p2, b2[0]);
					@(negedge clock);
					inst1_load = l1[0];
					inst2_load = l2[0];
					inst1_pc = p1;
					inst2_pc = p2;
					inst1_arn_dest = arn_t'(p1 >> 2);
					inst2_arn_dest = arn_t'(p2 >> 2);
					inst1_prn_dest = prn_t'(p1 >> 2);
					inst2_prn_dest = prn_t'(p2 >> 2);
					inst1_is_branch = b1[0];
					inst2_is_branch = b2[0];
					idx_check = 1'b1;
					exp_idx = idx_w'(idx);
					pulse_and_gap();
				end
				"C":
				begin
					code = $fscanf(fd, "%d %h %d %h %d %h %d %h", d1, i1, m1, t1,
						d2, i2, m2, t2);
					check_fields(kind, code, 8);
					// unit 1 recorded last, it wins on a shared index
					if (d2[0])
						u_checker.note_completion(idx_w'(i2), t2);
					if (d1[0])
						u_checker.note_completion(idx_w'(i1), t1);
					@(negedge clock);
					fu1_done = d1[0];
					fu1_idx = idx_w'(i1);
					fu1_mispredict = m1[0];
					fu1_target_pc = t1;
					fu2_done = d2[0];
					fu2_idx = idx_w'(i2);
					fu2_mispredict = m2[0];
					fu2_target_pc = t2;
					pulse_and_gap();
				end
				"W":
				begin
					code = $fscanf(fd, "%d", n);
					check_fields(kind, code, 1);
					repeat (n) @(negedge clock);
				end
				default:
				begin
					$display("trace has a row of unknown kind '%c'", kind);
					trace_errors++;
					code = $fgets(rest, fd);
				end
			endcase
		end
	endtask

	// watchdog, sized from the trace length
	initial
	begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clock);
		$display("timeout: trace not finished after %0d cycles", limit_cycles);
		$display("CHECKS FAILED");
		$finish;
	end

	initial
	begin
		void'($urandom(4));
		idle_inputs();
		trace_errors = 0;
		limit_cycles = 0;
		count_rows();
		limit_cycles = 40 * rows + 200;
		@(negedge reset);
		fd = $fopen("rob_trace.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the trace file rob_trace.txt");
			trace_errors++;
		end
		else
		begin
			run_trace();
			$fclose(fd);
			drain_test();
		end
		u_checker.finish_run();
		total = check_errors + trace_errors + DUT.u_pointers.chk.failures;
		if (total == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: rob_tb_checker.sv
//----------------------------------------------------------------------
// commit stream, index and occupancy checker for the reorder buffer
// expected commits are queued by the testbench, compared in order
//----------------------------------------------------------------------
`timescale 1ns/1ns

module rob_tb_checker #(
	parameter int rob_depth = rob_pkg::DEFAULT_ROB_DEPTH
) (
	input logic clock,
	input logic reset,
	input logic inst1_load,
	input logic inst2_load,
	input logic full,
	input logic commit1_valid,
	input rob_pkg::pc_t commit1_pc,
	input rob_pkg::arn_t commit1_arn_dest,
	input rob_pkg::prn_t commit1_prn_dest,
	input logic commit1_is_branch,
	input logic commit1_mispredict,
	input rob_pkg::pc_t commit1_target_pc,
	input logic commit2_valid,
	input rob_pkg::pc_t commit2_pc,
	input rob_pkg::arn_t commit2_arn_dest,
	input rob_pkg::prn_t commit2_prn_dest,
	input logic commit2_is_branch,
	input logic commit2_mispredict,
	input rob_pkg::pc_t commit2_target_pc,
	input logic [$clog2(rob_depth)-1:0] inst1_rob_idx,
	input logic [$clog2(rob_depth)-1:0] inst2_rob_idx,
	input logic idx_check,						// dispatch row in this cycle
	input logic [$clog2(rob_depth)-1:0] exp_idx,
	output int pending,							// expected commits not yet seen
	output int error_total
);
	import rob_pkg::*;

	localparam int idx_w = $clog2(rob_depth);

	pc_t exp_pc [$];
	logic exp_mis [$];
	logic exp_dual [$];	// must leave in a cycle with both slots valid
	logic branch_of [pc_t];	// branch flag of every dispatched pc
	pc_t target_at [rob_depth];	// last reported target per index
	logic [8*24-1:0] test_name;
	logic test_open = 1'b0;
	int test_errors = 0;
	int test_commits = 0;
	int tests_run = 0;
	int commits_total = 0;
	int occupancy = 0;	// live entries as the dispatch rules predict
	logic flush_seen;	// a mispredicted branch left in this cycle
	logic exp_full;

	initial
	begin
		pending = 0;
		error_total = 0;
		foreach (target_at[i])
			target_at[i] = '0;
	end

	task automatic note_error();
		test_errors++;
		error_total++;
	endtask

	task automatic expect_commit(input pc_t pc, input logic mis, input logic dual);
		exp_pc.push_back(pc);
		exp_mis.push_back(mis);
		exp_dual.push_back(dual);
		pending = exp_pc.size();
	endtask

	task automatic note_dispatch(input pc_t pc, input logic is_branch);
		branch_of[pc] = is_branch;
	endtask

	task automatic note_completion(input logic [idx_w-1:0] idx, input pc_t target);
		target_at[idx] = target;
	endtask

	task automatic close_test();
		if (test_open)
		begin
			$display("test %0s: %s, %0d commits, %0d errors", test_name,
				(test_errors == 0) ? "pass" : "fail", test_commits, test_errors);
			tests_run++;
		end
		test_open = 1'b0;
	endtask

	task automatic start_test(input logic [8*24-1:0] name);
		close_test();
		test_name = name;
		test_open = 1'b1;
		test_errors = 0;
		test_commits = 0;
	endtask

	task automatic finish_run();
		close_test();
		if (exp_pc.size() != 0)
		begin
			$display("%0d expected commits never appeared", exp_pc.size());
			error_total++;
		end
		$display("summary: %0d tests, %0d commits, %0d errors", tests_run,
			commits_total, error_total);
	endtask

	// one commit slot against the head of the expected queue
	task automatic check_slot(input int slot, input pc_t pc, input logic mis,
		input arn_t arn, input prn_t prn, input logic br, input pc_t tgt,
		input logic both);
		pc_t e_pc;
		logic e_mis;
		logic e_dual;
		logic e_br;
		logic [idx_w-1:0] e_idx;	// entries retire in index order
		e_idx = idx_w'(commits_total);
		test_commits++;
		commits_total++;
		if (exp_pc.size() == 0)
		begin
			$display("test %0s: unexpected commit of pc %h in slot %0d", test_name, pc, slot);
			note_error();
		end
		else
		begin
			e_pc = exp_pc.pop_front();
			e_mis = exp_mis.pop_front();
			e_dual = exp_dual.pop_front();
			e_br = branch_of.exists(e_pc) ? branch_of[e_pc] : 1'b0;
			pending = exp_pc.size();
			if (pc != e_pc)
			begin
				$display("MISMATCH %0s commit%0d pc expected %h actual %h", test_name, slot,
					e_pc, pc);
				note_error();
			end
			if (mis != e_mis)
			begin
				$display("MISMATCH %0s mispredict of pc %h expected %0b actual %0b", test_name,
					e_pc, e_mis, mis);
				note_error();
			end
			// destinations follow the pc, as the testbench dispatches them
			if (arn !== arn_t'(e_pc >> 2))
			begin
				$display("MISMATCH %0s commit%0d arn_dest expected %0d actual %0d", test_name,
					slot, arn_t'(e_pc >> 2), arn);
				note_error();
			end
			if (prn !== prn_t'(e_pc >> 2))
			begin
				$display("MISMATCH %0s commit%0d prn_dest expected %0d actual %0d", test_name,
					slot, prn_t'(e_pc >> 2), prn);
				note_error();
			end
			if (br !== e_br)
			begin
				$display("MISMATCH %0s is_branch of pc %h expected %0b actual %0b", test_name,
					e_pc, e_br, br);
				note_error();
			end
			if (tgt !== target_at[e_idx])
			begin
				$display("MISMATCH %0s target_pc of pc %h expected %h actual %h", test_name,
					e_pc, target_at[e_idx], tgt);
				note_error();
			end
			if (e_dual && !both)
			begin
				$display("test %0s: pc %h committed alone, expected a dual commit", test_name,
					pc);
				note_error();
			end
			if (e_mis && e_br)
				flush_seen = 1'b1;
		end
	endtask

	// expected occupancy, stepped once per rising edge
	task automatic track_occupancy();
		int accepted;
		accepted = 0;
		if (flush_seen)
			occupancy = 0;	// everything younger than the branch is gone
		else
		begin
			if (inst1_load && occupancy < rob_depth)
				accepted++;
			if (inst1_load && inst2_load && occupancy <= rob_depth - 2)
				accepted++;
			occupancy = occupancy + accepted - int'(commit1_valid) - int'(commit2_valid);
		end
	endtask

	// sampled at the rising edge, before the DUT registers move
	always @(posedge clock)
	begin
		if (!reset)
		begin
			if (idx_check && inst1_rob_idx != exp_idx)
			begin
				$display("MISMATCH %0s inst1_rob_idx expected %0d actual %0d", test_name,
					exp_idx, inst1_rob_idx);
				note_error();
			end
			if (idx_check && inst2_rob_idx != exp_idx + idx_w'(1))	// tail+1, wraps
			begin
				$display("MISMATCH %0s inst2_rob_idx expected %0d actual %0d", test_name,
					exp_idx + idx_w'(1), inst2_rob_idx);
				note_error();
			end
			exp_full = (rob_depth - occupancy) < 2;	// no room for a pair
			if (full !== exp_full)
			begin
				$display("MISMATCH %0s full expected %0b actual %0b", test_name, exp_full,
					full);
				note_error();
			end
			if (commit2_valid && !commit1_valid)
			begin
				$display("test %0s: commit slot 2 valid without slot 1", test_name);
				note_error();
			end
			flush_seen = 1'b0;
			if (commit1_valid)
				check_slot(1, commit1_pc, commit1_mispredict, commit1_arn_dest,
					commit1_prn_dest, commit1_is_branch, commit1_target_pc, commit2_valid);
			if (commit2_valid)
				check_slot(2, commit2_pc, commit2_mispredict, commit2_arn_dest,
					commit2_prn_dest, commit2_is_branch, commit2_target_pc, 1'b1);
			track_occupancy();
		end
	end

endmodule

// File: rob_tb_clock.sv
//----------------------------------------------------------------------
// testbench clock and reset for the reorder buffer
// 40 ns period, reset held high for the first 5 cycles
//----------------------------------------------------------------------
`timescale 1ns/1ns

module rob_tb_clock (
	output logic clock,
	output logic reset
);

	initial
	begin
		clock = 1'b0;
		reset = 1'b1;
		repeat (5) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;	// released on a falling edge like all stimulus
	end

	always #20 clock = ~clock;

endmodule

// File: rob_top.sv
//----------------------------------------------------------------------
// reorder buffer top level, two-wide dispatch, completion and commit
// connects storage, pointers and commit choice
//----------------------------------------------------------------------
`timescale 1ns/1ns

module rob_top #(
	parameter int rob_depth = rob_pkg::DEFAULT_ROB_DEPTH
) (
	input logic clock,
	input logic reset,
	// dispatch, slot 1
	input logic inst1_load,
	input rob_pkg::pc_t inst1_pc,
	input rob_pkg::arn_t inst1_arn_dest,
	input rob_pkg::prn_t inst1_prn_dest,
	input logic inst1_is_branch,
	// dispatch, slot 2
	input logic inst2_load,
	input rob_pkg::pc_t inst2_pc,
	input rob_pkg::arn_t inst2_arn_dest,
	input rob_pkg::prn_t inst2_prn_dest,
	input logic inst2_is_branch,
	// completion
	input logic fu1_done,
	input logic [$clog2(rob_depth)-1:0] fu1_idx,
	input logic fu1_mispredict,
	input rob_pkg::pc_t fu1_target_pc,
	input logic fu2_done,
	input logic [$clog2(rob_depth)-1:0] fu2_idx,
	input logic fu2_mispredict,
	input rob_pkg::pc_t fu2_target_pc,
	// indices handed back in the dispatch cycle
	output logic [$clog2(rob_depth)-1:0] inst1_rob_idx,
	output logic [$clog2(rob_depth)-1:0] inst2_rob_idx,
	output logic full,
	// commit, slot 1
	output logic commit1_valid,
	output rob_pkg::pc_t commit1_pc,
	output rob_pkg::arn_t commit1_arn_dest,
	output rob_pkg::prn_t commit1_prn_dest,
	output logic commit1_is_branch,
	output logic commit1_mispredict,
	output rob_pkg::pc_t commit1_target_pc,
	// commit, slot 2
	output logic commit2_valid,
	output rob_pkg::pc_t commit2_pc,
	output rob_pkg::arn_t commit2_arn_dest,
	output rob_pkg::prn_t commit2_prn_dest,
	output logic commit2_is_branch,
	output logic commit2_mispredict,
	output rob_pkg::pc_t commit2_target_pc
);
	import rob_pkg::*;

	localparam int idx_w = $clog2(rob_depth);
	localparam int cnt_w = $clog2(rob_depth+1);

	logic [idx_w-1:0] head;
	logic [idx_w-1:0] tail;
	logic [cnt_w-1:0] count;
	logic accept1;
	logic accept2;
	logic [1:0] commit_count;
	logic flush;
	logic head_valid, head_done, head_is_branch, head_mispredict;
	logic next_valid, next_done, next_is_branch, next_mispredict;
	pc_t head_pc, head_target_pc, next_pc, next_target_pc;
	arn_t head_arn, next_arn;
	prn_t head_prn, next_prn;

	// pair lands at tail and tail+1
	assign inst1_rob_idx = tail;
	assign inst2_rob_idx = tail + idx_w'(1);

	rob_pointers #(.rob_depth(rob_depth)) u_pointers (
		.clock(clock), .reset(reset),
		.inst1_load(inst1_load), .inst2_load(inst2_load),
		.commit_count(commit_count), .flush(flush),
		.head(head), .tail(tail), .count(count),
		.accept1(accept1), .accept2(accept2), .full(full)
	);

	rob_entry_array #(.rob_depth(rob_depth)) u_entries (
		.clock(clock), .reset(reset),
		.wr1_en(accept1), .wr2_en(accept2),
		.wr1_idx(inst1_rob_idx), .wr2_idx(inst2_rob_idx),
		.wr1_pc(inst1_pc), .wr2_pc(inst2_pc),
		.wr1_arn(inst1_arn_dest), .wr2_arn(inst2_arn_dest),
		.wr1_prn(inst1_prn_dest), .wr2_prn(inst2_prn_dest),
		.wr1_is_branch(inst1_is_branch), .wr2_is_branch(inst2_is_branch),
		.fu1_done(fu1_done), .fu2_done(fu2_done),
		.fu1_idx(fu1_idx), .fu2_idx(fu2_idx),
		.fu1_mispredict(fu1_mispredict), .fu2_mispredict(fu2_mispredict),
		.fu1_target_pc(fu1_target_pc), .fu2_target_pc(fu2_target_pc),
		.commit_count(commit_count), .flush(flush), .head_idx(head),
		.head_valid(head_valid), .head_done(head_done), .head_pc(head_pc),
		.head_arn(head_arn), .head_prn(head_prn), .head_is_branch(head_is_branch),
		.head_mispredict(head_mispredict), .head_target_pc(head_target_pc),
		.next_valid(next_valid), .next_done(next_done), .next_pc(next_pc),
		.next_arn(next_arn), .next_prn(next_prn), .next_is_branch(next_is_branch),
		.next_mispredict(next_mispredict), .next_target_pc(next_target_pc)
	);

	rob_commit_select #(.rob_depth(rob_depth)) u_commit (
		.count(count),
		.head_done(head_done), .head_is_branch(head_is_branch),
		.head_mispredict(head_mispredict),
		.next_done(next_done), .next_is_branch(next_is_branch),
		.next_mispredict(next_mispredict),
		.commit_count(commit_count), .flush(flush)
	);

	// commit ports, idle slots read as zero with the zero register
	assign commit1_valid = (commit_count != 2'd0) && head_valid;
	assign commit1_pc = commit1_valid ? head_pc : '0;
	assign commit1_arn_dest = commit1_valid ? head_arn : ZERO_REG;
	assign commit1_prn_dest = commit1_valid ? head_prn : '0;
	assign commit1_is_branch = commit1_valid && head_is_branch;
	assign commit1_mispredict = commit1_valid && head_mispredict;
	assign commit1_target_pc = commit1_valid ? head_target_pc : '0;

	assign commit2_valid = (commit_count == 2'd2) && next_valid;
	assign commit2_pc = commit2_valid ? next_pc : '0;
	assign commit2_arn_dest = commit2_valid ? next_arn : ZERO_REG;
	assign commit2_prn_dest = commit2_valid ? next_prn : '0;
	assign commit2_is_branch = commit2_valid && next_is_branch;
	assign commit2_mispredict = commit2_valid && next_mispredict;
	assign commit2_target_pc = commit2_valid ? next_target_pc : '0;

endmodule

// File: rob_trace.txt
# T name | E pc mispredict count dual | W cycles
# D load1 load2 pc1 pc2 branch1 branch2 expected_idx1 | C done1 idx1 mis1 tgt1 done2 idx2 mis2 tgt2
T in_order_commit
E 100 0 4 0
D 1 1 100 104 0 0 0
D 1 1 108 10c 0 0 2
C 1 3 0 0 1 2 0 0
C 1 1 0 0 1 0 0 0
T dual_commit
E 200 0 2 1
D 1 1 200 204 0 0 4
C 1 4 0 0 1 5 0 0
T index_return
E 300 0 3 0
D 1 0 300 0 0 0 6
D 1 1 304 308 0 0 7
C 1 6 0 0 1 7 0 0
C 1 8 0 0 0 0 0 0
T mispredict_flush
E 400 0 1 0
E 404 1 1 0
E 500 0 1 0
D 1 1 400 404 0 1 9
D 1 1 408 40c 0 0 b
C 1 c 0 0 1 b 0 0
C 1 a 1 500 1 9 0 0
W 3
D 1 0 500 0 0 0 b
C 1 b 0 0 0 0 0 0
T full_drop
E 600 0 16 0
D 1 1 600 604 0 0 c
D 1 1 608 60c 0 0 e
D 1 1 610 614 0 0 0
D 1 1 618 61c 0 0 2
D 1 1 620 624 0 0 4
D 1 1 628 62c 0 0 6
D 1 1 630 634 0 0 8
D 1 1 638 63c 0 0 a
D 1 1 6f0 6f4 0 0 c
D 1 0 6f8 0 0 0 c
C 1 c 0 0 1 d 0 0
C 1 e 0 0 1 f 0 0
C 1 0 0 0 1 1 0 0
C 1 2 0 0 1 3 0 0
C 1 4 0 0 1 5 0 0
C 1 6 0 0 1 7 0 0
C 1 8 0 0 1 9 0 0
C 1 a 0 0 1 b 0 0
T wraparound
E 700 0 18 0
D 1 1 700 704 0 0 c
C 1 c 0 0 1 d 0 0
D 1 1 708 70c 0 0 e
C 1 e 0 0 1 f 0 0
D 1 1 710 714 0 0 0
C 1 0 0 0 1 1 0 0
D 1 1 718 71c 0 0 2
C 1 2 0 0 1 3 0 0
D 1 1 720 724 0 0 4
C 1 4 0 0 1 5 0 0
D 1 1 728 72c 0 0 6
C 1 6 0 0 1 7 0 0
D 1 1 730 734 0 0 8
C 1 8 0 0 1 9 0 0
D 1 1 738 73c 0 0 a
C 1 a 0 0 1 b 0 0
D 1 1 740 744 0 0 c
C 1 c 0 0 1 d 0 0

// File: run_sim.sh
#!/bin/bash
# build and run the reorder buffer testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module rob_tb -f rob.f -o rob_sim \
	&& ./obj_dir/rob_sim +verilator+error+limit+100 > sim.log 2>&1 \
	|| echo "build or simulation ended abnormally"
cat sim.log 2>/dev/null
grep -qx "ALL CHECKS PASSED" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
